// File: src/if_cfg_pkg.sv
/*
 * fetch stage configuration package
 * address and instruction word types, boot and vector constants, APB register map
 */

package if_cfg_pkg;

  // bus word types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // boot entry sits 0x80 into the 256-byte aligned boot region
  localparam addr_t       BootOffset   = 32'h0000_0080;
  localparam int unsigned VecAlignBits = 8;

  // APB register map, byte offsets
  localparam int unsigned         ApbAddrW    = 4;
  localparam logic [ApbAddrW-1:0] RegBootAddr = 4'h0;
  localparam logic [ApbAddrW-1:0] RegMtvec    = 4'h4;
  localparam logic [ApbAddrW-1:0] RegMepc     = 4'h8;
  localparam logic [ApbAddrW-1:0] RegDepc     = 4'hC;

  // debug ROM entry points
  localparam addr_t DmHaltAddrDefault      = 32'h1A11_0800;
  localparam addr_t DmExceptionAddrDefault = 32'h1A11_0808;

  // all internal interrupts share the NMI slot
  localparam logic [4:0] NmiVecIdx = 5'd31;

endpackage

// File: src/if_ctrl_pkg.sv
/*
 * fetch stage control encodings
 * PC mux selects, exception PC selects and the exception cause layout
 */

package if_ctrl_pkg;

  // source of the next fetch address on a PC set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // which handler entry PC_EXC jumps to
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // cause as delivered by the controller
  // lower_cause doubles as the vector index for external interrupts
  typedef struct packed {
    logic       irq_ext;
    logic       irq_int;
    logic [4:0] lower_cause;
  } exc_cause_t;

endpackage

// File: src/if_bus_ifs.sv
/*
 * internal bundles of the fetch stage
 * csr_vec_if: address registers to the PC mux
 * fetch_if: prefetch buffer to the IF-ID register
 */

// level signals only, no handshake
interface csr_vec_if import if_cfg_pkg::*; ();
  addr_t boot_addr;
  addr_t mtvec;
  addr_t mepc;
  addr_t depc;

  modport src (output boot_addr, output mtvec, output mepc, output depc);
  modport dst (input boot_addr, input mtvec, input mepc, input depc);
endinterface

// a word moves when valid and ready are both high
// flush marks the PC-set cycle, valid is low then
interface fetch_if import if_cfg_pkg::*; ();
  logic   valid;
  logic   ready;
  instr_t rdata;
  addr_t  addr;
  logic   err;
  logic   flush;

  modport out (output valid, output rdata, output addr, output err, output flush, input ready);
  modport in  (input valid, input rdata, input addr, input err, input flush, output ready);
endinterface

// File: src/if_csr_regs.sv
/*
 * APB slave with the boot address, mtvec, mepc and depc registers
 * mtvec is reloaded from the boot address on a boot PC set
 */

module if_csr_regs import if_cfg_pkg::*, if_ctrl_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                apb_psel_i,
  input  logic                apb_penable_i,
  input  logic                apb_pwrite_i,
  input  logic [ApbAddrW-1:0] apb_paddr_i,
  input  logic [31:0]         apb_pwdata_i,
  output logic [31:0]         apb_prdata_o,
  output logic                apb_pready_o,
  output logic                apb_pslverr_o,
  input  logic                pc_set_i,
  input  pc_sel_e             pc_mux_i,
  csr_vec_if.src              vec_o
);

  localparam int unsigned BaseW = 32 - VecAlignBits;

  // boot and mtvec keep only the aligned base, low byte reads as zero
  logic [BaseW-1:0] boot_base_q;
  logic [BaseW-1:0] mtvec_base_q;
  addr_t            mepc_q;
  addr_t            depc_q;
  addr_t            boot_addr;
  addr_t            mtvec;
  logic             access;
  logic             hit;
  logic             mtvec_init;
  logic [31:0]      rdata;

  assign boot_addr = {boot_base_q, {VecAlignBits{1'b0}}};
  assign mtvec     = {mtvec_base_q, {VecAlignBits{1'b0}}};

  //////////////////////////////
  // APB decode
  //////////////////////////////

  // access phase, pready is tied high so this is the last cycle
  assign access = apb_psel_i & apb_penable_i;

  always_comb begin
    hit   = 1'b1;
    rdata = '0;
    case (apb_paddr_i)
      RegBootAddr: rdata = boot_addr;
      RegMtvec:    rdata = mtvec;
      RegMepc:     rdata = mepc_q;
      RegDepc:     rdata = depc_q;
      // misaligned offsets fall here
      default:     hit = 1'b0;
    endcase
  end

  assign apb_prdata_o  = (access & ~apb_pwrite_i) ? rdata : '0;
  assign apb_pready_o  = 1'b1;
  assign apb_pslverr_o = access & ~hit;

  // boot PC set seeds the trap vector
  assign mtvec_init = pc_set_i & (pc_mux_i == PC_BOOT);

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_base_q  <= '0;
      mtvec_base_q <= '0;
      mepc_q       <= '0;
      depc_q       <= '0;
    end else begin
      if (access && apb_pwrite_i) begin
        case (apb_paddr_i)
          RegBootAddr: boot_base_q  <= apb_pwdata_i[31:VecAlignBits];
          RegMtvec:    mtvec_base_q <= apb_pwdata_i[31:VecAlignBits];
          RegMepc:     mepc_q       <= apb_pwdata_i;
          RegDepc:     depc_q       <= apb_pwdata_i;
          default:     ;
        endcase
      end
      // boot load overrides a write in the same cycle
      if (mtvec_init) begin
        mtvec_base_q <= boot_base_q;
      end
    end
  end

  assign vec_o.boot_addr = boot_addr;
  assign vec_o.mtvec     = mtvec;
  assign vec_o.mepc      = mepc_q;
  assign vec_o.depc      = depc_q;

endmodule

// File: src/if_pc_mux.sv
/*
 * next fetch address selection
 * exception and interrupt vector, debug entries, return addresses
 */

module if_pc_mux import if_cfg_pkg::*, if_ctrl_pkg::*; #(
  parameter addr_t DmHaltAddr      = DmHaltAddrDefault,
  parameter addr_t DmExceptionAddr = DmExceptionAddrDefault
) (
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  exc_cause_t  exc_cause_i,
  input  addr_t       branch_target_ex_i,
  csr_vec_if.dst      vec_i,
  output addr_t       fetch_addr_o
);

  addr_t      boot_entry;
  addr_t      mtvec_base;
  addr_t      exc_pc;
  logic [4:0] irq_idx;

  // bases with the alignment bits forced clear
  assign boot_entry = {vec_i.boot_addr[31:VecAlignBits], {VecAlignBits{1'b0}}} + BootOffset;
  assign mtvec_base = {vec_i.mtvec[31:VecAlignBits], {VecAlignBits{1'b0}}};

  // internal interrupts go to the NMI slot, external ones use their own line
  assign irq_idx = exc_cause_i.irq_int ? NmiVecIdx : exc_cause_i.lower_cause;

  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      // vectored mode, one word per slot
      EXC_PC_IRQ:     exc_pc = mtvec_base | addr_t'({irq_idx, 2'b00});
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = mtvec_base;
    endcase
  end

  always_comb begin
    case (pc_mux_i)
      PC_BOOT: fetch_addr_o = boot_entry;
      PC_JUMP: fetch_addr_o = branch_target_ex_i;
      PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_o = vec_i.mepc;
      // return from debug mode
      PC_DRET: fetch_addr_o = vec_i.depc;
      // unused encodings restart at the boot entry
      default: fetch_addr_o = boot_entry;
    endcase
  end

endmodule

// File: src/if_prefetch_buffer.sv
/*
 * word prefetch buffer, master on the req/gnt/rvalid instruction bus
 * tracks outstanding and discarded responses, holds words in a small FIFO
 */

module if_prefetch_buffer import if_cfg_pkg::*; #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   req_i,
  input  logic   pc_set_i,
  input  addr_t  fetch_addr_i,
  output logic   instr_req_o,
  output addr_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  instr_t instr_rdata_i,
  input  logic   instr_err_i,
  output logic   busy_o,
  fetch_if.out   fetch_o
);

  localparam int unsigned CntW = $clog2(FifoDepth + 1);
  localparam int unsigned PtrW = $clog2(FifoDepth);

  instr_t          fifo_data_q [FifoDepth];
  addr_t           fifo_addr_q [FifoDepth];
  logic            fifo_err_q  [FifoDepth];
  logic [PtrW-1:0] rd_ptr_q, wr_ptr_q;
  logic [CntW-1:0] fifo_cnt_q, outst_q, outst_d, discard_q;
  logic [CntW:0]   in_use;
  addr_t           req_addr_q, redir_addr_q, rsp_addr_q, target;
  logic            armed_q, hold_q, redir_q;
  logic            room, grant, hold_redir, drop, push, pop;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // request side
  //////////////////////////////

  assign target = {fetch_addr_i[31:2], 2'b00};
  // buffered plus in-flight words must stay below the FIFO size
  assign in_use = fifo_cnt_q + outst_q;
  assign room   = in_use < FifoDepth;

  // nothing is fetched before the first PC set after reset
  // a request not yet granted is held even across a PC set
  assign instr_req_o  = hold_q | (armed_q & req_i & room & ~pc_set_i);
  assign instr_addr_o = req_addr_q;
  assign grant        = instr_req_o & instr_gnt_i;
  // redirect arrives while an old request still waits for its grant
  assign hold_redir   = pc_set_i & hold_q & ~instr_gnt_i;

  // responses of requests issued before the flush are dropped
  assign drop    = instr_rvalid_i & ((discard_q != '0) | pc_set_i);
  assign push    = instr_rvalid_i & ~drop;
  assign outst_d = outst_q + CntW'(grant) - CntW'(instr_rvalid_i);

  assign busy_o = instr_req_o | (outst_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q      <= 1'b0;
      hold_q       <= 1'b0;
      redir_q      <= 1'b0;
      req_addr_q   <= '0;
      redir_addr_q <= '0;
      rsp_addr_q   <= '0;
      outst_q      <= '0;
      discard_q    <= '0;
      fifo_cnt_q   <= '0;
      rd_ptr_q     <= '0;
      wr_ptr_q     <= '0;
    end else begin
      armed_q <= armed_q | pc_set_i;
      hold_q  <= instr_req_o & ~instr_gnt_i;
      outst_q <= outst_d;
      if (pc_set_i) begin
        // everything still in flight is stale now
        discard_q  <= outst_d;
        rsp_addr_q <= target;
        fifo_cnt_q <= '0;
        rd_ptr_q   <= '0;
        wr_ptr_q   <= '0;
      end else begin
        // the held request granted after a redirect is stale as well
        discard_q  <= discard_q - CntW'(drop) + CntW'(grant & redir_q);
        fifo_cnt_q <= fifo_cnt_q + CntW'(push) - CntW'(pop);
        if (push) begin
          wr_ptr_q   <= ptr_inc(wr_ptr_q);
          rsp_addr_q <= rsp_addr_q + 32'd4;
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
      end
      // next request address
      if (pc_set_i && !hold_redir) begin
        req_addr_q <= target;
      end else if (grant) begin
        req_addr_q <= redir_q ? redir_addr_q : req_addr_q + 32'd4;
      end
      if (hold_redir) begin
        redir_q      <= 1'b1;
        redir_addr_q <= target;
      end else if (grant) begin
        redir_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // response FIFO
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fifo_data_q <= '{default: '0};
      fifo_addr_q <= '{default: '0};
      fifo_err_q  <= '{default: 1'b0};
    end else if (push) begin
      fifo_data_q[wr_ptr_q] <= instr_rdata_i;
      fifo_addr_q[wr_ptr_q] <= rsp_addr_q;
      fifo_err_q[wr_ptr_q]  <= instr_err_i;
    end
  end

  assign pop           = fetch_o.valid & fetch_o.ready;
  assign fetch_o.valid = (fifo_cnt_q != '0) & ~pc_set_i;
  assign fetch_o.rdata = fifo_data_q[rd_ptr_q];
  assign fetch_o.addr  = fifo_addr_q[rd_ptr_q];
  assign fetch_o.err   = fifo_err_q[rd_ptr_q];
  assign fetch_o.flush = pc_set_i;

endmodule

// File: src/if_id_stage_reg.sv
/*
 * IF-ID pipeline register
 * sequential PC consistency alarm
 */

module if_id_stage_reg import if_cfg_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   id_in_ready_i,
  input  logic   instr_valid_clear_i,
  fetch_if.in    fetch_i,
  output logic   instr_valid_id_o,
  output logic   instr_new_id_o,
  output instr_t instr_rdata_id_o,
  output logic   instr_fetch_err_o,
  output addr_t  pc_id_o,
  output addr_t  pc_if_o,
  output logic   pc_mismatch_alert_o
);

  logic  xfer;
  logic  seq_q;
  addr_t pc_next_seq;

  // ID stall backs straight up into the prefetch FIFO
  assign fetch_i.ready = id_in_ready_i;
  assign xfer          = fetch_i.valid & id_in_ready_i;
  assign pc_if_o       = fetch_i.addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
      seq_q            <= 1'b0;
    end else begin
      // valid stays up until the ID side clears it
      instr_valid_id_o <= xfer | (instr_valid_id_o & ~instr_valid_clear_i);
      instr_new_id_o   <= xfer;
      // no check right after a redirect or a faulting fetch
      seq_q            <= (seq_q | xfer) & ~fetch_i.flush & ~(xfer & fetch_i.err);
    end
  end

  // payload frozen while ID stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else if (xfer) begin
      instr_rdata_id_o  <= fetch_i.rdata;
      instr_fetch_err_o <= fetch_i.err;
      pc_id_o           <= fetch_i.addr;
    end
  end

  //////////////////////////////
  // PC consistency
  //////////////////////////////

  // every word is 4 bytes, so a sequential stream steps by 4
  assign pc_next_seq = pc_id_o + 32'd4;

  // only a word on offer has a meaningful address
  assign pc_mismatch_alert_o = seq_q & fetch_i.valid & (fetch_i.addr != pc_next_seq);

endmodule

// File: src/if_stage_top.sv
/*
 * instruction fetch stage top level
 * CSR block, PC mux, prefetch buffer and IF-ID register
 */

module if_stage_top import if_cfg_pkg::*, if_ctrl_pkg::*; #(
  parameter addr_t       DmHaltAddr      = DmHaltAddrDefault,
  parameter addr_t       DmExceptionAddr = DmExceptionAddrDefault,
  parameter int unsigned FifoDepth       = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // APB slave
  input  logic                apb_psel_i,
  input  logic                apb_penable_i,
  input  logic                apb_pwrite_i,
  input  logic [ApbAddrW-1:0] apb_paddr_i,
  input  logic [31:0]         apb_pwdata_i,
  output logic [31:0]         apb_prdata_o,
  output logic                apb_pready_o,
  output logic                apb_pslverr_o,
  input  logic                req_i,
  // instruction bus
  output logic                instr_req_o,
  output addr_t               instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  instr_t              instr_rdata_i,
  input  logic                instr_err_i,
  // control
  input  logic                pc_set_i,
  input  pc_sel_e             pc_mux_i,
  input  exc_pc_sel_e         exc_pc_mux_i,
  input  exc_cause_t          exc_cause_i,
  input  addr_t               branch_target_ex_i,
  // ID side
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output instr_t              instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output addr_t               pc_if_o,
  output addr_t               pc_id_o,
  // status
  output logic                pc_mismatch_alert_o,
  output logic                if_busy_o
);

  addr_t fetch_addr;

  csr_vec_if u_csr_vec ();
  fetch_if   u_fetch ();

  if_csr_regs u_csr_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .apb_psel_i   (apb_psel_i),
    .apb_penable_i(apb_penable_i),
    .apb_pwrite_i (apb_pwrite_i),
    .apb_paddr_i  (apb_paddr_i),
    .apb_pwdata_i (apb_pwdata_i),
    .apb_prdata_o (apb_prdata_o),
    .apb_pready_o (apb_pready_o),
    .apb_pslverr_o(apb_pslverr_o),
    .pc_set_i     (pc_set_i),
    .pc_mux_i     (pc_mux_i),
    .vec_o        (u_csr_vec.src)
  );

  // mux sits next to the registers it reads
  if_pc_mux #(
    .DmHaltAddr     (DmHaltAddr),
    .DmExceptionAddr(DmExceptionAddr)
  ) u_pc_mux (
    .pc_mux_i          (pc_mux_i),
    .exc_pc_mux_i      (exc_pc_mux_i),
    .exc_cause_i       (exc_cause_i),
    .branch_target_ex_i(branch_target_ex_i),
    .vec_i             (u_csr_vec.dst),
    .fetch_addr_o      (fetch_addr)
  );

  if_prefetch_buffer #(
    .FifoDepth(FifoDepth)
  ) u_prefetch_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .pc_set_i      (pc_set_i),
    .fetch_addr_i  (fetch_addr),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .instr_err_i   (instr_err_i),
    .busy_o        (if_busy_o),
    .fetch_o       (u_fetch.out)
  );

  if_id_stage_reg u_id_stage_reg (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .id_in_ready_i      (id_in_ready_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .fetch_i            (u_fetch.in),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o),
    .instr_rdata_id_o   (instr_rdata_id_o),
    .instr_fetch_err_o  (instr_fetch_err_o),
    .pc_id_o            (pc_id_o),
    .pc_if_o            (pc_if_o),
    .pc_mismatch_alert_o(pc_mismatch_alert_o)
  );

endmodule

// File: sim/if_stage_props.sv
/*
 * concurrent checks on the instruction bus and the PC-set behaviour
 * bound into the fetch stage top level
 */

module if_stage_props import if_cfg_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  req_i,
  input addr_t addr_i,
  input logic  gnt_i,
  input logic  pc_set_i,
  input logic  new_i
);

  // assertion failures so far
  int unsigned n_fail = 0;

  // word fetch only
  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (addr_i[1:0] == 2'b00))
    else begin
      n_fail++;
      $error("instruction request address is not word aligned");
    end

  // a request waits with a fixed address until it is granted
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !gnt_i) |=> (req_i && $stable(addr_i)))
    else begin
      n_fail++;
      $error("instruction request dropped or changed before its grant");
    end

  // nothing is handed over in the PC-set cycle
  a_no_new_after_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !new_i)
    else begin
      n_fail++;
      $error("new instruction right after a PC set");
    end

endmodule

bind if_stage_top if_stage_props u_props (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .req_i   (instr_req_o),
  .addr_i  (instr_addr_o),
  .gnt_i   (instr_gnt_i),
  .pc_set_i(pc_set_i),
  .new_i   (instr_new_id_o)
);

// File: sim/tb_if_stage.sv
/*
 * fetch stage testbench
 * clock, reset, instruction bus and APB models, reference target, compare process
 */

module tb_if_stage import if_cfg_pkg::*, if_ctrl_pkg::*; ();

  logic                clk_i;
  logic                rst_ni;
  logic                apb_psel_i;
  logic                apb_penable_i;
  logic                apb_pwrite_i;
  logic [ApbAddrW-1:0] apb_paddr_i;
  logic [31:0]         apb_pwdata_i;
  logic [31:0]         apb_prdata_o;
  logic                apb_pready_o;
  logic                apb_pslverr_o;
  logic                req_i;
  logic                instr_req_o;
  addr_t               instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  instr_t              instr_rdata_i;
  logic                instr_err_i;
  logic                pc_set_i;
  pc_sel_e             pc_mux_i;
  exc_pc_sel_e         exc_pc_mux_i;
  exc_cause_t          exc_cause_i;
  addr_t               branch_target_ex_i;
  logic                id_in_ready_i;
  logic                instr_valid_clear_i;
  logic                instr_valid_id_o;
  logic                instr_new_id_o;
  instr_t              instr_rdata_id_o;
  logic                instr_fetch_err_o;
  addr_t               pc_if_o;
  addr_t               pc_id_o;
  logic                pc_mismatch_alert_o;
  logic                if_busy_o;

  // register values as last written over APB
  addr_t       boot_m, mtvec_m, mepc_m, depc_m;
  // target of the pending PC set and the next expected PC
  addr_t       set_target, exp_pc;
  int unsigned words_seen;
  logic        hold_off;

  if_stage_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic instr_t mem_word(addr_t addr);
    return addr ^ 32'h5A5A_0000;
  endfunction

  // the 0xE000 page of every 64 KiB block faults
  function automatic logic mem_err(addr_t addr);
    return addr[15:12] == 4'hE;
  endfunction

  function automatic logic reg_mapped(logic [ApbAddrW-1:0] addr);
    return addr inside {RegBootAddr, RegMtvec, RegMepc, RegDepc};
  endfunction

  // boot and mtvec read back without their low byte
  function automatic addr_t exp_reg(logic [ApbAddrW-1:0] addr);
    addr_t val;
    case (addr)
      RegBootAddr: val = {boot_m[31:8], 8'h00};
      RegMtvec:    val = {mtvec_m[31:8], 8'h00};
      RegMepc:     val = mepc_m;
      default:     val = depc_m;
    endcase
    return val;
  endfunction

  function automatic addr_t exp_target(pc_sel_e sel, exc_pc_sel_e esel, exc_cause_t cause,
                                       addr_t branch);
    addr_t      vec_base;
    addr_t      handler;
    addr_t      target;
    logic [4:0] slot;
    vec_base = {mtvec_m[31:8], 8'h00};
    slot     = cause.irq_int ? NmiVecIdx : cause.lower_cause;
    case (esel)
      EXC_PC_IRQ:     handler = vec_base + 4 * slot;
      EXC_PC_DBD:     handler = DmHaltAddrDefault;
      EXC_PC_DBG_EXC: handler = DmExceptionAddrDefault;
      default:        handler = vec_base;
    endcase
    case (sel)
      PC_JUMP: target = branch;
      PC_EXC:  target = handler;
      PC_ERET: target = mepc_m;
      PC_DRET: target = depc_m;
      default: target = {boot_m[31:8], 8'h00} + BootOffset;
    endcase
    return target;
  endfunction

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic stop_on_error();
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic fail_timeout(string what);
    $display("timed out waiting for %s at %0t", what, $time);
    stop_on_error();
  endtask

  task automatic check_addr(string what, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_instr(string what, instr_t got, instr_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  //////////////////////////////
  // bus and ID stall model
  //////////////////////////////

  // in-order responses with random grant and response delay
  initial begin : bus_model
    addr_t rsp_q[$];
    void'($urandom(32'h3a408231));
    forever begin
      @(posedge clk_i);
      // busy covers a pending request and every granted word still owed a response
      if (rst_ni) begin
        check_bit("fetch busy", if_busy_o, instr_req_o || (rsp_q.size() != 0));
      end
      if (instr_rvalid_i) begin
        void'(rsp_q.pop_front());
      end
      if (instr_req_o && instr_gnt_i) begin
        rsp_q.push_back(instr_addr_o);
      end
      @(negedge clk_i);
      instr_gnt_i = ($urandom_range(3, 0) != 0);
      if (rsp_q.size() != 0 && $urandom_range(2, 0) != 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = mem_word(rsp_q[0]);
        instr_err_i    = mem_err(rsp_q[0]);
      end else begin
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        instr_err_i    = 1'b0;
      end
      // ID side stalls and clears at random
      id_in_ready_i       = hold_off ? 1'b0 : ($urandom_range(3, 0) != 0);
      instr_valid_clear_i = ($urandom_range(3, 0) == 0);
    end
  end

  // IF-ID outputs are sampled at the rising edge before any flop changes
  initial begin : compare_proc
    addr_t  last_pc;
    addr_t  last_pc_if;
    instr_t last_rdata;
    logic   last_err, last_valid, last_clear, last_rdy;
    last_pc    = '0;
    last_pc_if = '0;
    last_rdata = '0;
    last_err   = 1'b0;
    last_valid = 1'b0;
    last_clear = 1'b0;
    last_rdy   = 1'b1;
    forever begin
      @(posedge clk_i);
      if (rst_ni) begin
        if (i_dut.u_props.n_fail != 0) begin
          $display("a bound assertion failed before %0t", $time);
          stop_on_error();
        end
        check_bit("pc mismatch alert", pc_mismatch_alert_o, 1'b0);
        check_bit("valid flag", instr_valid_id_o, instr_new_id_o | (last_valid & ~last_clear));
        // nothing may move after a stalled cycle
        if (!last_rdy) begin
          check_bit("new flag under stall", instr_new_id_o, 1'b0);
          check_addr("held pc", pc_id_o, last_pc);
          check_instr("held instruction", instr_rdata_id_o, last_rdata);
          check_bit("held fetch error", instr_fetch_err_o, last_err);
        end
        if (instr_new_id_o) begin
          check_addr("pc_if of the word taken", last_pc_if, exp_pc);
          check_addr("pc_id", pc_id_o, exp_pc);
          check_instr("instruction", instr_rdata_id_o, mem_word(exp_pc));
          check_bit("fetch error", instr_fetch_err_o, mem_err(exp_pc));
          exp_pc     = exp_pc + 32'd4;
          words_seen = words_seen + 1;
        end
        // redirect applies after the last word of the old stream
        if (pc_set_i) begin
          exp_pc     = set_target;
          words_seen = 0;
        end
      end
      last_pc    = pc_id_o;
      last_pc_if = pc_if_o;
      last_rdata = instr_rdata_id_o;
      last_err   = instr_fetch_err_o;
      last_valid = instr_valid_id_o;
      last_clear = instr_valid_clear_i;
      last_rdy   = id_in_ready_i;
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  task automatic apb_access(logic write, logic [ApbAddrW-1:0] addr, logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    apb_psel_i    = 1'b1;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = write;
    apb_paddr_i   = addr;
    apb_pwdata_i  = wdata;
    @(negedge clk_i);
    apb_penable_i = 1'b1;
    @(posedge clk_i);
    while (!apb_pready_o) begin
      cycles++;
      if (cycles > 16) begin
        fail_timeout("APB pready");
      end
      @(posedge clk_i);
    end
    rdata  = apb_prdata_o;
    slverr = apb_pslverr_o;
    @(negedge clk_i);
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(logic [ApbAddrW-1:0] addr, logic [31:0] data);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, data, rdata, slverr);
    check_bit("pslverr on write", slverr, !reg_mapped(addr));
    case (addr)
      RegBootAddr: boot_m = data;
      RegMtvec:    mtvec_m = data;
      RegMepc:     mepc_m = data;
      RegDepc:     depc_m = data;
      default:     ;
    endcase
  endtask

  task automatic apb_read_check(logic [ApbAddrW-1:0] addr);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b0, addr, '0, rdata, slverr);
    check_bit("pslverr on read", slverr, !reg_mapped(addr));
    if (reg_mapped(addr)) begin
      check_addr("APB read data", rdata, exp_reg(addr));
    end
  endtask

  task automatic wait_words(int unsigned n);
    int unsigned cycles;
    cycles = 0;
    while (words_seen < n) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 60 * n + 200) begin
        fail_timeout("fetched instructions");
      end
    end
  endtask

  // one-cycle PC set followed by n words of the new stream
  task automatic redirect(pc_sel_e sel, exc_pc_sel_e esel, exc_cause_t cause, addr_t branch,
                          int unsigned n);
    @(negedge clk_i);
    pc_mux_i           = sel;
    exc_pc_mux_i       = esel;
    exc_cause_i        = cause;
    branch_target_ex_i = branch;
    set_target         = exp_target(sel, esel, cause, branch);
    pc_set_i           = 1'b1;
    @(negedge clk_i);
    pc_set_i = 1'b0;
    if (sel == PC_BOOT) begin
      mtvec_m = boot_m;
    end
    wait_words(n);
  endtask

  // full FIFO under a held ID stage stops the bus
  task automatic wait_fifo_full();
    int unsigned cycles;
    cycles = 0;
    while (if_busy_o || id_in_ready_i) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 200) begin
        fail_timeout("the prefetch FIFO to fill");
      end
    end
  endtask

  //////////////////////////////
  // scenarios
  //////////////////////////////

  initial begin : main_seq
    int unsigned n_held;
    exc_cause_t  no_cause;
    no_cause            = '0;
    rst_ni              = 1'b0;
    apb_psel_i          = 1'b0;
    apb_penable_i       = 1'b0;
    apb_pwrite_i        = 1'b0;
    apb_paddr_i         = '0;
    apb_pwdata_i        = '0;
    req_i               = 1'b1;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_err_i         = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_cause_i         = '0;
    branch_target_ex_i  = '0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    boot_m              = '0;
    mtvec_m             = '0;
    mepc_m              = '0;
    depc_m              = '0;
    set_target          = '0;
    exp_pc              = '0;
    words_seen          = 0;
    hold_off            = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    // register readback and unmapped offsets
    apb_write(RegBootAddr, 32'h0000_2137);
    apb_write(RegMtvec, 32'h0000_41FF);
    apb_write(RegMepc, 32'h0000_3000);
    apb_write(RegDepc, 32'h0000_5004);
    apb_read_check(RegBootAddr);
    apb_read_check(RegMtvec);
    apb_read_check(RegMepc);
    apb_read_check(RegDepc);
    apb_write(4'h2, 32'hFFFF_FFFF);
    apb_read_check(4'h7);

    // boot followed by a long sequential stream under random stalls
    redirect(PC_BOOT, EXC_PC_EXC, no_cause, '0, 40);
    apb_read_check(RegMtvec);
    apb_write(RegMtvec, 32'h0000_6000);

    // jump runs into the faulting page
    redirect(PC_JUMP, EXC_PC_EXC, no_cause, 32'h0000_DFF0, 8);
    redirect(PC_ERET, EXC_PC_EXC, no_cause, '0, 6);
    redirect(PC_DRET, EXC_PC_EXC, no_cause, '0, 6);
    redirect(PC_EXC, EXC_PC_EXC, no_cause, '0, 6);
    // internal interrupt ignores lower_cause
    redirect(PC_EXC, EXC_PC_IRQ, exc_cause_t'(7'b01_00011), '0, 6);
    redirect(PC_EXC, EXC_PC_IRQ, exc_cause_t'(7'b10_00101), '0, 6);
    redirect(PC_EXC, EXC_PC_DBD, no_cause, '0, 6);
    redirect(PC_EXC, EXC_PC_DBG_EXC, no_cause, '0, 6);

    // back-pressure holds until the FIFO is full and is then released
    hold_off = 1'b1;
    wait_fifo_full();
    // one more edge so the last word taken has been counted
    @(negedge clk_i);
    // two buffered words sit between the next expected PC and the next request
    check_addr("next request address with a full FIFO", instr_addr_o, exp_pc + 32'd8);
    n_held   = words_seen;
    hold_off = 1'b0;
    wait_words(n_held + 8);

    if (i_dut.u_props.n_fail == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("bound assertions failed during the run");
      stop_on_error();
    end
  end

endmodule

// File: filelist.f
src/if_cfg_pkg.sv
src/if_ctrl_pkg.sv
src/if_bus_ifs.sv
src/if_csr_regs.sv
src/if_pc_mux.sv
src/if_prefetch_buffer.sv
src/if_id_stage_reg.sv
src/if_stage_top.sv
sim/if_stage_props.sv
sim/tb_if_stage.sv
